// File: hdl/mhp_pkg.sv
package mhp_pkg;

  // header field widths as seen by the link layer
  localparam int TASK_NUM_W = 8;
  localparam int SEG_IDX_W  = 8;   // segment index and segment count
  localparam int HDR_SIZE_W = 11;  // packet size in bytes
  localparam int BYTE_W     = 8;

  // pong frame payload length in bytes
  localparam int PONG_BYTES = 4;

  // pong payload, built as a task map and sent out byte by byte
  typedef union packed {
    logic [PONG_BYTES*BYTE_W-1:0]      task_map;  // bit k is task k+1
    logic [PONG_BYTES-1:0][BYTE_W-1:0] bytes;     // byte 0 leaves first
  } pong_payload_u;

endpackage

// File: hdl/task_cfg_pkg.sv
package task_cfg_pkg;

  // task numbers run 1..MAX_TASKS, the pong map has one bit each
  localparam int MAX_TASKS = 32;

  // bit k set means task k+1 is built into this accelerator
  // only task 8 (floating point butterfly) is present for now
  localparam logic [MAX_TASKS-1:0] ENABLED_TASKS = 32'h0000_0080;

endpackage

// File: hdl/frame_sequencer.sv
`timescale 1ns/10ps

module frame_sequencer #(
  parameter int PACKET_SIZE_WIDTH = 12,
  parameter int SEG_BYTES_LOG2    = 10
) (
  input  logic                                 i_clk,
  input  logic                                 i_rst,
  input  logic                                 i_rx_valid,
  input  logic                                 i_rx_ping,
  input  logic [mhp_pkg::HDR_SIZE_W-1:0]       i_rx_packet_size,
  input  logic [mhp_pkg::SEG_IDX_W-1:0]        i_rx_segment_index,
  input  logic [mhp_pkg::SEG_IDX_W-1:0]        i_rx_segments_number,
  input  logic                                 i_tx_busy,
  input  logic                                 i_tx_header_sent,
  input  logic                                 i_tx_ack,
  input  logic                                 i_sel_request,
  input  logic                                 i_sel_answer_ready,
  input  logic [mhp_pkg::BYTE_W-1:0]           i_sel_answer_data,
  input  logic [PACKET_SIZE_WIDTH-1:0]         i_sel_answer_size,
  input  logic [mhp_pkg::TASK_NUM_W-1:0]       i_grant,
  output logic                                 o_tx_ping,
  output logic [mhp_pkg::TASK_NUM_W-1:0]       o_tx_task_number,
  output logic [mhp_pkg::HDR_SIZE_W-1:0]       o_tx_packet_size,
  output logic [mhp_pkg::SEG_IDX_W-1:0]        o_tx_segment_index,
  output logic [mhp_pkg::SEG_IDX_W-1:0]        o_tx_segments_number,
  output logic                                 o_tx_hdr_req,
  output logic                                 o_tx_valid,
  output logic [mhp_pkg::BYTE_W-1:0]           o_tx_data,
  output logic                                 o_fwd_valid,
  output logic                                 o_fwd_last,
  output logic                                 o_answer_take,
  output logic                                 o_grant_advance,
  output logic                                 o_idle
);

  localparam logic [2:0] S_IDLE        = 3'd0;
  localparam logic [2:0] S_READ_PING   = 3'd1;
  localparam logic [2:0] S_READ_TASK   = 3'd2;
  localparam logic [2:0] S_SEND_HDR    = 3'd3;
  localparam logic [2:0] S_SEND_PONG   = 3'd4;
  localparam logic [2:0] S_SEND_ANSWER = 3'd5;
  localparam logic [2:0] S_WAIT_LINK   = 3'd6;

  localparam int HW     = mhp_pkg::HDR_SIZE_W;
  localparam int PIDX_W = $clog2(mhp_pkg::PONG_BYTES);
  localparam logic [PACKET_SIZE_WIDTH-1:0] SEG_BYTES = PACKET_SIZE_WIDTH'(1 << SEG_BYTES_LOG2);

  logic [2:0]                   state;
  logic [2:0]                   next_state;
  logic [HW-1:0]                cnt;        // bytes of current frame or segment
  logic [HW-1:0]                last_size;  // size of final segment
  logic                         rx_drop;
  logic                         rx_start;
  logic                         ans_start;
  logic                         rx_last_byte;
  logic                         tx_move;
  logic [PACKET_SIZE_WIDTH-1:0] ans_rem;
  logic [PACKET_SIZE_WIDTH-1:0] ans_segs;
  logic [PACKET_SIZE_WIDTH-1:0] ans_first;
  mhp_pkg::pong_payload_u       pong;

  assign pong = task_cfg_pkg::ENABLED_TASKS;

  // segment split of the granted answer
  assign ans_rem   = i_sel_answer_size & (SEG_BYTES - 1'b1);
  assign ans_segs  = (i_sel_answer_size >> SEG_BYTES_LOG2) + PACKET_SIZE_WIDTH'(ans_rem != '0);
  assign ans_first = (i_sel_answer_size > SEG_BYTES) ? SEG_BYTES : i_sel_answer_size;

  assign rx_start     = (state == S_IDLE) && i_rx_valid && !i_tx_busy && !rx_drop;
  assign ans_start    = (state == S_IDLE) && !i_rx_valid && !i_tx_busy && i_sel_answer_ready;
  assign rx_last_byte = (cnt == i_rx_packet_size - 1'b1);
  assign tx_move      = o_tx_valid && i_tx_ack;

  assign o_fwd_valid = !i_rx_ping &&
                       ((rx_start && i_sel_request) || (state == S_READ_TASK && i_rx_valid));
  assign o_fwd_last  = o_fwd_valid && rx_last_byte &&
                       (i_rx_segment_index == i_rx_segments_number - 1'b1);

  assign o_tx_hdr_req    = (state == S_SEND_HDR);
  assign o_tx_valid      = (state == S_SEND_PONG) || (state == S_SEND_ANSWER && i_sel_answer_ready);
  assign o_tx_data       = (state == S_SEND_PONG) ? pong.bytes[cnt[PIDX_W-1:0]] : i_sel_answer_data;
  assign o_answer_take   = (state == S_SEND_ANSWER) && i_sel_answer_ready && i_tx_ack;
  assign o_grant_advance = (state == S_IDLE) && !i_sel_answer_ready;
  assign o_idle          = (state == S_IDLE);

  always_comb begin
    next_state = state;
    case (state)
      S_IDLE: begin
        if (rx_start) begin
          if (i_rx_ping)
            next_state = S_READ_PING;
          else if (i_sel_request && !rx_last_byte)
            next_state = S_READ_TASK;  // one-byte frame stays idle
        end else if (ans_start) begin
          next_state = S_SEND_HDR;
        end
      end
      S_READ_PING:
        if (!i_rx_valid) next_state = S_SEND_HDR;
      S_READ_TASK:
        if (i_rx_valid && rx_last_byte) next_state = S_IDLE;
      S_SEND_HDR:
        if (i_tx_header_sent) next_state = o_tx_ping ? S_SEND_PONG : S_SEND_ANSWER;
      S_SEND_PONG:
        if (i_tx_ack && cnt == HW'(mhp_pkg::PONG_BYTES - 1)) next_state = S_IDLE;
      S_SEND_ANSWER: begin
        if (o_answer_take && cnt == o_tx_packet_size - 1'b1) begin
          if (o_tx_segment_index == o_tx_segments_number - 1'b1)
            next_state = S_IDLE;
          else
            next_state = S_WAIT_LINK;
        end
      end
      S_WAIT_LINK:
        if (!i_tx_busy) next_state = S_SEND_HDR;
      default: next_state = S_IDLE;
    endcase
  end

  always_ff @(posedge i_clk) begin
    if (i_rst)
      state <= S_IDLE;
    else
      state <= next_state;
  end

  always_ff @(posedge i_clk) begin
    if (i_rst)
      cnt <= '0;
    else if (state == S_IDLE && next_state == S_READ_TASK)
      cnt <= HW'(1);  // first byte went out while idle
    else if (state != next_state)
      cnt <= '0;
    else if (state != S_IDLE && (o_fwd_valid || tx_move))
      cnt <= cnt + 1'b1;
  end

  // refused frame is ignored until valid drops
  always_ff @(posedge i_clk) begin
    if (i_rst || !i_rx_valid)
      rx_drop <= 1'b0;
    else if (rx_start && !i_rx_ping && !i_sel_request)
      rx_drop <= 1'b1;
  end

  always_ff @(posedge i_clk) begin
    if (state == S_READ_PING && !i_rx_valid) begin
      o_tx_ping            <= 1'b1;
      o_tx_task_number     <= '0;
      o_tx_packet_size     <= HW'(mhp_pkg::PONG_BYTES);
      o_tx_segment_index   <= '0;
      o_tx_segments_number <= mhp_pkg::SEG_IDX_W'(1);
    end else if (ans_start) begin
      o_tx_ping            <= 1'b0;
      o_tx_task_number     <= i_grant + 1'b1;
      o_tx_packet_size     <= ans_first[HW-1:0];
      o_tx_segment_index   <= '0;
      o_tx_segments_number <= ans_segs[mhp_pkg::SEG_IDX_W-1:0];
      last_size            <= (ans_rem != '0) ? ans_rem[HW-1:0] : SEG_BYTES[HW-1:0];
    end else if (state == S_WAIT_LINK && !i_tx_busy) begin
      o_tx_segment_index <= o_tx_segment_index + 1'b1;
      if (o_tx_segment_index + mhp_pkg::SEG_IDX_W'(2) == o_tx_segments_number)
        o_tx_packet_size <= last_size;  // next one is the tail
      else
        o_tx_packet_size <= SEG_BYTES[HW-1:0];
    end
  end

  // answer payload never runs past the size in its header
  a_ans_cnt_range: assert property (@(posedge i_clk) disable iff (i_rst)
    (state == S_SEND_ANSWER) |-> (cnt < o_tx_packet_size))
    else $error("answer byte count past segment size");

endmodule

// File: hdl/task_port_switch.sv
`timescale 1ns/10ps

module task_port_switch #(
  parameter int TASK_PORTS        = 10,
  parameter int PACKET_SIZE_WIDTH = 12
) (
  input  logic                                         i_clk,
  input  logic                                         i_rst,
  input  logic [mhp_pkg::TASK_NUM_W-1:0]               i_rx_task_number,
  input  logic [mhp_pkg::BYTE_W-1:0]                   i_rx_data,
  input  logic                                         i_fwd_valid,
  input  logic                                         i_fwd_last,
  input  logic                                         i_grant_advance,
  input  logic                                         i_answer_take,
  input  logic [TASK_PORTS-1:0]                        i_task_request,
  input  logic [TASK_PORTS-1:0]                        i_answer_ready,
  input  logic [TASK_PORTS-1:0][mhp_pkg::BYTE_W-1:0]   i_answer_data,
  input  logic [TASK_PORTS-1:0][PACKET_SIZE_WIDTH-1:0] i_answer_size,
  output logic [TASK_PORTS-1:0][mhp_pkg::BYTE_W-1:0]   o_task_data,
  output logic [TASK_PORTS-1:0]                        o_task_valid,
  output logic [TASK_PORTS-1:0]                        o_task_last,
  output logic [TASK_PORTS-1:0]                        o_answer_take,
  output logic                                         o_sel_request,
  output logic                                         o_sel_answer_ready,
  output logic [mhp_pkg::BYTE_W-1:0]                   o_sel_answer_data,
  output logic [PACKET_SIZE_WIDTH-1:0]                 o_sel_answer_size,
  output logic [mhp_pkg::TASK_NUM_W-1:0]               o_grant
);

  localparam int TW = mhp_pkg::TASK_NUM_W;
  localparam logic [TW-1:0] LAST_PORT = TW'(TASK_PORTS - 1);

  logic [TW-1:0]         rx_port;
  logic [TASK_PORTS-1:0] rx_hit;
  logic [TASK_PORTS-1:0] grant_hit;

  assign rx_port = i_rx_task_number - 1'b1;  // task 0 wraps out of range

  always_comb begin
    rx_hit             = '0;
    grant_hit          = '0;
    o_sel_request      = 1'b0;
    o_sel_answer_ready = 1'b0;
    o_sel_answer_data  = '0;
    o_sel_answer_size  = '0;
    for (int p = 0; p < TASK_PORTS; p++) begin
      if (rx_port == TW'(p)) begin
        rx_hit[p]     = 1'b1;
        o_sel_request = i_task_request[p];
      end
      if (o_grant == TW'(p)) begin
        grant_hit[p]       = 1'b1;
        o_sel_answer_ready = i_answer_ready[p];
        o_sel_answer_data  = i_answer_data[p];
        o_sel_answer_size  = i_answer_size[p];
      end
    end
  end

  assign o_answer_take = grant_hit & {TASK_PORTS{i_answer_take}};

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_task_valid <= '0;
      o_task_last  <= '0;
    end else begin
      o_task_valid <= rx_hit & {TASK_PORTS{i_fwd_valid}};
      o_task_last  <= rx_hit & {TASK_PORTS{i_fwd_valid && i_fwd_last}};
    end
  end

  always_ff @(posedge i_clk) begin
    for (int p = 0; p < TASK_PORTS; p++) begin
      if (rx_hit[p] && i_fwd_valid) o_task_data[p] <= i_rx_data;
    end
  end

  // round robin grant parks on a port that has an answer
  always_ff @(posedge i_clk) begin
    if (i_rst)
      o_grant <= '0;
    else if (i_grant_advance)
      o_grant <= (o_grant == LAST_PORT) ? '0 : o_grant + 1'b1;
  end

  a_take_needs_ready: assert property (@(posedge i_clk) disable iff (i_rst)
    (o_answer_take & ~i_answer_ready) == '0)
    else $error("answer taken from a port with no answer ready");

  a_grant_range: assert property (@(posedge i_clk) disable iff (i_rst)
    o_grant <= LAST_PORT)
    else $error("grant past last task port");

endmodule

// File: hdl/transaction_watchdog.sv
`timescale 1ns/10ps

module transaction_watchdog #(
  parameter int WATCHDOG_CYCLES = 1024
) (
  input  logic i_clk,
  input  logic i_rst,
  input  logic i_idle,
  output logic o_busy,
  output logic o_watchdog_trig
);

  localparam int CNT_W = $clog2(WATCHDOG_CYCLES + 1);

  logic [CNT_W-1:0] count;

  // reload while idle, run down otherwise
  always_ff @(posedge i_clk) begin
    if (i_rst || i_idle)
      count <= CNT_W'(WATCHDOG_CYCLES);
    else if (count != '0)
      count <= count - 1'b1;
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_busy          <= 1'b0;
      o_watchdog_trig <= 1'b0;
    end else begin
      o_busy <= !i_idle;
      if (i_idle)
        o_watchdog_trig <= 1'b0;
      else if (count == '0)
        o_watchdog_trig <= 1'b1;  // sticky until back in idle
    end
  end

endmodule

// File: hdl/task_manager.sv
`timescale 1ns/10ps

module task_manager #(
  parameter int TASK_PORTS        = 10,  // 1..32
  parameter int PACKET_SIZE_WIDTH = 12,  // 11..18
  parameter int SEG_BYTES_LOG2    = 10,
  parameter int WATCHDOG_CYCLES   = 32'h0EE6_B27F
) (
  input  logic                                           i_clk,
  input  logic                                           i_rst,
  // rx from link layer
  input  logic                                           i_rx_valid,
  input  logic [mhp_pkg::BYTE_W-1:0]                     i_rx_data,
  input  logic                                           i_rx_ping,
  input  logic [mhp_pkg::TASK_NUM_W-1:0]                 i_rx_task_number,
  input  logic [mhp_pkg::HDR_SIZE_W-1:0]                 i_rx_packet_size,
  input  logic [mhp_pkg::SEG_IDX_W-1:0]                  i_rx_segment_index,
  input  logic [mhp_pkg::SEG_IDX_W-1:0]                  i_rx_segments_number,
  // tx to link layer
  output logic                                           o_tx_ping,
  output logic [mhp_pkg::TASK_NUM_W-1:0]                 o_tx_task_number,
  output logic [mhp_pkg::HDR_SIZE_W-1:0]                 o_tx_packet_size,
  output logic [mhp_pkg::SEG_IDX_W-1:0]                  o_tx_segment_index,
  output logic [mhp_pkg::SEG_IDX_W-1:0]                  o_tx_segments_number,
  output logic                                           o_tx_hdr_req,
  output logic                                           o_tx_valid,
  output logic [mhp_pkg::BYTE_W-1:0]                     o_tx_data,
  input  logic                                           i_tx_header_sent,
  input  logic                                           i_tx_ack,
  input  logic                                           i_tx_busy,
  // task ports, port p serves task p+1
  output logic [TASK_PORTS-1:0][mhp_pkg::BYTE_W-1:0]     o_task_data,
  output logic [TASK_PORTS-1:0]                          o_task_valid,
  output logic [TASK_PORTS-1:0]                          o_task_last,
  output logic [TASK_PORTS-1:0]                          o_answer_take,
  input  logic [TASK_PORTS-1:0]                          i_task_request,
  input  logic [TASK_PORTS-1:0]                          i_answer_ready,
  input  logic [TASK_PORTS-1:0][mhp_pkg::BYTE_W-1:0]     i_answer_data,
  input  logic [TASK_PORTS-1:0][PACKET_SIZE_WIDTH-1:0]   i_answer_size,
  // status
  output logic                                           o_busy,
  output logic                                           o_watchdog_trig
);

  logic                               fwd_valid;
  logic                               fwd_last;
  logic                               grant_advance;
  logic                               answer_take;
  logic                               idle;
  logic                               sel_request;
  logic                               sel_answer_ready;
  logic [mhp_pkg::BYTE_W-1:0]         sel_answer_data;
  logic [PACKET_SIZE_WIDTH-1:0]       sel_answer_size;
  logic [mhp_pkg::TASK_NUM_W-1:0]     grant;

  frame_sequencer #(
    .PACKET_SIZE_WIDTH (PACKET_SIZE_WIDTH),
    .SEG_BYTES_LOG2    (SEG_BYTES_LOG2)
  ) u_sequencer (
    .i_clk                (i_clk),
    .i_rst                (i_rst),
    .i_rx_valid           (i_rx_valid),
    .i_rx_ping            (i_rx_ping),
    .i_rx_packet_size     (i_rx_packet_size),
    .i_rx_segment_index   (i_rx_segment_index),
    .i_rx_segments_number (i_rx_segments_number),
    .i_tx_busy            (i_tx_busy),
    .i_tx_header_sent     (i_tx_header_sent),
    .i_tx_ack             (i_tx_ack),
    .i_sel_request        (sel_request),
    .i_sel_answer_ready   (sel_answer_ready),
    .i_sel_answer_data    (sel_answer_data),
    .i_sel_answer_size    (sel_answer_size),
    .i_grant              (grant),
    .o_tx_ping            (o_tx_ping),
    .o_tx_task_number     (o_tx_task_number),
    .o_tx_packet_size     (o_tx_packet_size),
    .o_tx_segment_index   (o_tx_segment_index),
    .o_tx_segments_number (o_tx_segments_number),
    .o_tx_hdr_req         (o_tx_hdr_req),
    .o_tx_valid           (o_tx_valid),
    .o_tx_data            (o_tx_data),
    .o_fwd_valid          (fwd_valid),
    .o_fwd_last           (fwd_last),
    .o_answer_take        (answer_take),
    .o_grant_advance      (grant_advance),
    .o_idle               (idle)
  );

  task_port_switch #(
    .TASK_PORTS        (TASK_PORTS),
    .PACKET_SIZE_WIDTH (PACKET_SIZE_WIDTH)
  ) u_switch (
    .i_clk              (i_clk),
    .i_rst              (i_rst),
    .i_rx_task_number   (i_rx_task_number),
    .i_rx_data          (i_rx_data),
    .i_fwd_valid        (fwd_valid),
    .i_fwd_last         (fwd_last),
    .i_grant_advance    (grant_advance),
    .i_answer_take      (answer_take),
    .i_task_request     (i_task_request),
    .i_answer_ready     (i_answer_ready),
    .i_answer_data      (i_answer_data),
    .i_answer_size      (i_answer_size),
    .o_task_data        (o_task_data),
    .o_task_valid       (o_task_valid),
    .o_task_last        (o_task_last),
    .o_answer_take      (o_answer_take),
    .o_sel_request      (sel_request),
    .o_sel_answer_ready (sel_answer_ready),
    .o_sel_answer_data  (sel_answer_data),
    .o_sel_answer_size  (sel_answer_size),
    .o_grant            (grant)
  );

  transaction_watchdog #(
    .WATCHDOG_CYCLES (WATCHDOG_CYCLES)
  ) u_watchdog (
    .i_clk           (i_clk),
    .i_rst           (i_rst),
    .i_idle          (idle),
    .o_busy          (o_busy),
    .o_watchdog_trig (o_watchdog_trig)
  );

endmodule

// File: tb/tb_task_manager.sv
`timescale 1ns/10ps

module tb_task_manager;

  localparam int PORTS       = 4;
  localparam int SEG_BYTES   = 16;
  localparam int CLK_PERIOD  = 4;
  localparam int TEST_CYCLES = 5000;  // six tests at well under 800 cycles each

  logic                      i_clk;
  logic                      i_rst;
  logic                      i_rx_valid;
  logic [7:0]                i_rx_data;
  logic                      i_rx_ping;
  logic [7:0]                i_rx_task_number;
  logic [10:0]               i_rx_packet_size;
  logic [7:0]                i_rx_segment_index;
  logic [7:0]                i_rx_segments_number;
  logic                      o_tx_ping;
  logic [7:0]                o_tx_task_number;
  logic [10:0]               o_tx_packet_size;
  logic [7:0]                o_tx_segment_index;
  logic [7:0]                o_tx_segments_number;
  logic                      o_tx_hdr_req;
  logic                      o_tx_valid;
  logic [7:0]                o_tx_data;
  logic                      i_tx_header_sent;
  logic                      i_tx_ack;
  logic                      i_tx_busy;
  logic [PORTS-1:0][7:0]     o_task_data;
  logic [PORTS-1:0]          o_task_valid;
  logic [PORTS-1:0]          o_task_last;
  logic [PORTS-1:0]          o_answer_take;
  logic [PORTS-1:0]          i_task_request;
  logic [PORTS-1:0]          i_answer_ready;
  logic [PORTS-1:0][7:0]     i_answer_data;
  logic [PORTS-1:0][11:0]    i_answer_size;
  logic                      o_busy;
  logic                      o_watchdog_trig;

  integer      seed;
  logic        hdr_hold;     // link model withholds header-sent
  logic        busy_mode;    // link model holds busy after payload
  int          busy_hold;
  logic [35:0] exp_hdr [$];  // {ping, task, size, index, count}
  logic [7:0]  exp_tx [$];
  logic [8:0]  exp_task [PORTS][$];  // {last, data}
  logic [7:0]  answer_q [PORTS][$];

  wire [35:0] tx_hdr = {o_tx_ping, o_tx_task_number, o_tx_packet_size,
                        o_tx_segment_index, o_tx_segments_number};
  wire [6:0]  ctrl = {o_tx_hdr_req, o_tx_valid, |o_task_valid, |o_task_last,
                      |o_answer_take, o_busy, o_watchdog_trig};

  task_manager #(
    .TASK_PORTS        (PORTS),
    .PACKET_SIZE_WIDTH (12),
    .SEG_BYTES_LOG2    (4),
    .WATCHDOG_CYCLES   (64)
  ) dut (.*);

  task automatic report_mismatch(input string name, input logic [63:0] exp_v,
                                 input logic [63:0] act_v);
    $display("CHECK FAILED at %0t ns: %s expected %0h actual %0h", $time, name, exp_v, act_v);
    $display("TESTS FAILED");
    $fatal(1, "stopping at first error");
  endtask

  task automatic report_error(input string msg);
    $display("ERROR at %0t ns: %s", $time, msg);
    $display("TESTS FAILED");
    $fatal(1, "stopping at first error");
  endtask

  initial begin
    i_clk = 1'b0;
    forever #(CLK_PERIOD / 2) i_clk = ~i_clk;
  end

  initial begin
    #(TEST_CYCLES * CLK_PERIOD);
    report_error("simulation did not finish in time");
  end

  // link layer model
  always begin
    int rnd;
    @(posedge i_clk);
    #1;
    rnd = $random(seed);
    i_tx_ack = rnd[0];
    i_tx_header_sent = o_tx_hdr_req && !hdr_hold && !i_tx_header_sent;
    i_tx_busy = busy_mode && (busy_hold != 0);
    if (busy_hold != 0) busy_hold = busy_hold - 1;
  end

  // task answer models with one byte queue per port
  always begin
    logic [PORTS-1:0] taken;
    @(negedge i_clk);
    taken = o_answer_take;
    @(posedge i_clk);
    #1;
    for (int p = 0; p < PORTS; p++) begin
      if (taken[p] && answer_q[p].size() != 0) void'(answer_q[p].pop_front());
      i_answer_ready[p] = (answer_q[p].size() != 0);
      i_answer_data[p] = (answer_q[p].size() != 0) ? answer_q[p][0] : 8'h00;
    end
  end

  // scoreboards sample mid cycle
  always @(negedge i_clk) begin
    if (!i_rst) begin
      if (o_tx_hdr_req && i_tx_header_sent) begin
        if (exp_hdr.size() == 0) report_error("header sent that was not expected");
        assert (tx_hdr == exp_hdr[0]) else report_mismatch("tx header", exp_hdr[0], tx_hdr);
        void'(exp_hdr.pop_front());
      end
      if (o_tx_valid && i_tx_ack) begin
        if (exp_tx.size() == 0) report_error("tx payload byte that was not expected");
        assert (o_tx_data == exp_tx[0]) else report_mismatch("o_tx_data", exp_tx[0], o_tx_data);
        void'(exp_tx.pop_front());
        busy_hold = 6;
      end
      for (int p = 0; p < PORTS; p++) begin
        if (o_task_valid[p]) begin
          if (exp_task[p].size() == 0) report_error("task byte on a port that expects none");
          assert ({o_task_last[p], o_task_data[p]} == exp_task[p][0])
            else report_mismatch("o_task_last/o_task_data", exp_task[p][0],
                                 {o_task_last[p], o_task_data[p]});
          void'(exp_task[p].pop_front());
        end
      end
    end
  end

  a_hdr_stable: assert property (@(posedge i_clk) disable iff (i_rst)
    (o_tx_hdr_req && !i_tx_header_sent) |=> $stable(tx_hdr))
    else report_error("tx header changed while its request was pending");

  // a link still busy holds back every answer header
  a_hdr_waits_link: assert property (@(posedge i_clk) disable iff (i_rst)
    ($rose(o_tx_hdr_req) && !o_tx_ping) |-> !$past(i_tx_busy))
    else report_error("answer header requested while the link was busy");

  a_busy_follows: assert property (@(posedge i_clk) disable iff (i_rst)
    (o_tx_hdr_req || o_tx_valid) |=> o_busy)
    else report_mismatch("o_busy", 1, 0);

  task automatic next_cycle();
    @(posedge i_clk);
    #1;
  endtask

  task automatic send_rx_frame(input logic ping, input int task_num, input int n_bytes,
                               input int first);
    i_rx_ping = ping;
    i_rx_task_number = 8'(task_num);
    i_rx_packet_size = 11'(n_bytes);
    i_rx_segment_index = 8'd0;
    i_rx_segments_number = 8'd1;
    for (int i = 0; i < n_bytes; i++) begin
      i_rx_valid = 1'b1;
      i_rx_data = 8'(first + i);
      next_cycle();
    end
    i_rx_valid = 1'b0;
  endtask

  // expected headers and bytes of an answer from the segment rules
  task automatic load_answer(input int port, input int size, input int first);
    int segs;
    int sz;
    segs = (size + SEG_BYTES - 1) / SEG_BYTES;
    for (int s = 0; s < segs; s++) begin
      sz = (s == segs - 1) ? size - SEG_BYTES * s : SEG_BYTES;
      exp_hdr.push_back({1'b0, 8'(port + 1), 11'(sz), 8'(s), 8'(segs)});
    end
    i_answer_size[port] = 12'(size);
    for (int i = 0; i < size; i++) begin
      exp_tx.push_back(8'(first + 3 * i));
      answer_q[port].push_back(8'(first + 3 * i));
    end
  endtask

  task automatic wait_quiet(input int limit);
    int n;
    int pending;
    n = 0;
    pending = 1;
    while (pending != 0) begin
      next_cycle();
      n++;
      if (n > limit) report_error("DUT did not finish the transaction");
      pending = exp_hdr.size() + exp_tx.size() + o_busy + i_tx_busy;
      for (int p = 0; p < PORTS; p++) pending += exp_task[p].size();
    end
    repeat (3) next_cycle();
  endtask

  initial begin
    int n;
    seed = 32;
    hdr_hold = 1'b0;
    busy_mode = 1'b0;
    busy_hold = 0;
    i_rst = 1'b1;
    i_rx_valid = 1'b0;
    i_rx_data = '0;
    i_rx_ping = 1'b0;
    i_rx_task_number = '0;
    i_rx_packet_size = '0;
    i_rx_segment_index = '0;
    i_rx_segments_number = '0;
    i_tx_header_sent = 1'b0;
    i_tx_ack = 1'b0;
    i_tx_busy = 1'b0;
    i_task_request = '0;
    i_answer_ready = '0;
    i_answer_data = '0;
    i_answer_size = '0;
    repeat (3) @(posedge i_clk);
    #1 i_rst = 1'b0;

    repeat (4) begin
      next_cycle();
      assert (ctrl == 7'd0) else report_mismatch("control outputs after reset", 0, ctrl);
    end

    // pong carries the enabled task map lsb first
    exp_hdr.push_back({1'b1, 8'd0, 11'd4, 8'd0, 8'd1});
    for (int i = 0; i < 4; i++) exp_tx.push_back(8'(task_cfg_pkg::ENABLED_TASKS >> (8 * i)));
    send_rx_frame(1'b1, 0, 2, 8'h50);
    wait_quiet(200);

    // task frame to port 2 and a refused one to port 1
    i_task_request = 4'b0100;
    for (int i = 0; i < 10; i++) exp_task[2].push_back({(i == 9), 8'(8'hA0 + i)});
    send_rx_frame(1'b0, 3, 10, 8'hA0);
    wait_quiet(100);
    send_rx_frame(1'b0, 2, 5, 8'h10);
    wait_quiet(100);
    i_task_request = '0;

    load_answer(1, 9, 8'h21);
    wait_quiet(300);

    busy_mode = 1'b1;
    load_answer(3, 40, 8'h05);
    wait_quiet(800);
    busy_mode = 1'b0;

    // header never confirmed so the watchdog has to fire
    hdr_hold = 1'b1;
    load_answer(0, 3, 8'hC0);
    n = 0;
    while (!o_watchdog_trig) begin
      next_cycle();
      n++;
      if (n > 300) report_error("watchdog did not trigger on a stuck header");
    end
    assert (n > 64) else report_mismatch("o_watchdog_trig delay in cycles", 65, n);
    hdr_hold = 1'b0;
    wait_quiet(300);
    assert (!o_watchdog_trig) else report_mismatch("o_watchdog_trig after idle", 0, 1);

    $display("TESTS PASSED");
    $finish;
  end

endmodule

// File: compile.f
hdl/mhp_pkg.sv
hdl/task_cfg_pkg.sv
hdl/frame_sequencer.sv
hdl/task_port_switch.sv
hdl/transaction_watchdog.sv
hdl/task_manager.sv
tb/tb_task_manager.sv

// File: run.sh
#!/bin/sh
# build and run the task manager testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_task_manager \
  -f compile.f -o sim_tb > build.log 2>&1 \
  || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log
grep -qx "TESTS PASSED" sim.log && exit 0 || exit 1
